// ==== hw/periph_settings.svh ====
/*
 * Peripheral bus settings
 * Slot count, bus widths and the register address map
 */
`ifndef PERIPH_SETTINGS_SVH
`define PERIPH_SETTINGS_SVH

// Byte slots, 1 to 16
`define PERIPH_NUM_SLOTS     8
`define PERIPH_ADDR_W        11
`define PERIPH_PINS          8

// Address map
`define PERIPH_SLOT_BIT      10
`define PERIPH_GPIO_BLOCK    1
`define PERIPH_GPIO_OUT_OFS  6'h00
`define PERIPH_GPIO_IN_OFS   6'h04
`define PERIPH_GPIO_SEL_OFS  6'h20

// Per slot register layout
`define PERIPH_SLOT_REGS     4
`define PERIPH_SLOT_IN_OFS   4

`endif

// ==== hw/periph_pkg.sv ====
/*
 * Peripheral bus types
 * Data widths, access size codes and the pin function select
 */
`default_nettype none

`include "periph_settings.svh"

package periph_pkg;

    typedef logic [7:0]              byte_t;
    typedef logic [31:0]             word_t;
    typedef logic [`PERIPH_PINS-1:0] pins_t;

    // Access size: 00 byte, 01 half, 10 word, 11 no access
    typedef logic [1:0] size_code_t;
    localparam size_code_t SIZE_IDLE = 2'b11;

    // Pin function select
    // Bit 4 set routes a byte slot, index in bits 3:0
    // Bit 4 clear gives a source code in bits 3:0
    typedef logic [4:0] func_sel_t;

    // Source code of the GPIO output register
    localparam logic [3:0] FUNC_GPIO = 4'd1;
    localparam func_sel_t  FUNC_SEL_RESET = {1'b0, FUNC_GPIO};

    // Pin outputs of every byte slot
    typedef pins_t [`PERIPH_NUM_SLOTS-1:0] slot_pins_t;

endpackage

`default_nettype wire

// ==== hw/slot_bus_if.sv ====
/*
 * Byte slot bus
 * Links the address decoder, one byte slot and the read-return block
 */
`default_nettype none

interface slot_bus_if;
    import periph_pkg::*;

    // Register offset inside the slot
    logic [3:0] offset;
    byte_t      wdata;

    // One cycle write, always accepted
    logic       write;

    // Combinational from offset
    byte_t      rdata;

    // Slot outputs towards the pin mux
    pins_t      pins;

    modport decoder (
        output offset,
        output wdata,
        output write
    );

    modport periph (
        input  offset,
        input  wdata,
        input  write,
        output rdata,
        output pins
    );

    modport reader (
        input  rdata
    );

endinterface

`default_nettype wire

// ==== hw/bus_decoder.sv ====
/*
 * Peripheral address decoder
 * Turns the CPU address and write code into slot and GPIO write strobes
 */
`default_nettype none

`include "periph_settings.svh"

module bus_decoder #(
    parameter int NUM_SLOTS = `PERIPH_NUM_SLOTS
) (
    input  wire logic [`PERIPH_ADDR_W-1:0] i_addr,
    input  wire periph_pkg::word_t         i_data,
    input  wire periph_pkg::size_code_t    i_data_write_n,
    output logic                           o_gpio_write,
    output logic [5:0]                     o_gpio_ofs,
    output periph_pkg::byte_t              o_wdata,
    slot_bus_if.decoder                    slot_bus [NUM_SLOTS]
);
    import periph_pkg::*;

    logic       wr_req;
    logic       slot_region;
    logic [3:0] slot_idx;
    logic [3:0] block_idx;

    assign wr_req      = i_data_write_n != SIZE_IDLE;
    assign slot_region = i_addr[`PERIPH_SLOT_BIT];

    // 16 bytes per slot in the slot region
    assign slot_idx    = i_addr[7:4];

    // 64 bytes per block in the word region
    assign block_idx   = i_addr[9:6];

    // GPIO block strobes
    assign o_gpio_write = wr_req && !slot_region &&
                          block_idx == 4'(`PERIPH_GPIO_BLOCK);
    assign o_gpio_ofs   = i_addr[5:0];
    assign o_wdata      = i_data[7:0];

    // Offset and data go to every slot, the write only to the addressed one
    // Slot indices past NUM_SLOTS match no slot
    for (genvar s = 0; s < NUM_SLOTS; s++) begin : g_slot
        assign slot_bus[s].offset = i_addr[3:0];
        assign slot_bus[s].wdata  = i_data[7:0];
        assign slot_bus[s].write  = wr_req && slot_region && slot_idx == 4'(s);
    end

endmodule

`default_nettype wire

// ==== hw/byte_periph.sv ====
/*
 * Byte peripheral slot
 * Four read/write byte registers and an input pin read port
 */
`default_nettype none

`include "periph_settings.svh"

module byte_periph (
    input  wire logic              clk,
    input  wire logic              rst_n,
    input  wire periph_pkg::pins_t i_ui_in,
    slot_bus_if.periph             bus
);
    import periph_pkg::*;

    localparam int IDX_W = $clog2(`PERIPH_SLOT_REGS);

    byte_t            regs [`PERIPH_SLOT_REGS];
    logic             reg_hit;
    logic             in_hit;
    logic [IDX_W-1:0] reg_idx;

    // Registers sit at the lowest offsets
    assign reg_hit = bus.offset < 4'(`PERIPH_SLOT_REGS);
    assign in_hit  = bus.offset == 4'(`PERIPH_SLOT_IN_OFS);
    assign reg_idx = bus.offset[IDX_W-1:0];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int r = 0; r < `PERIPH_SLOT_REGS; r++) begin
                regs[r] <= '0;
            end
        end else if (bus.write && reg_hit) begin
            regs[reg_idx] <= bus.wdata;
        end
    end

    // Read back is combinational from the offset
    always_comb begin
        if (reg_hit) begin
            bus.rdata = regs[reg_idx];
        end else if (in_hit) begin
            bus.rdata = i_ui_in;
        end else begin
            bus.rdata = '0;
        end
    end

    // Register 0 drives this slot's pins
    assign bus.pins = regs[0];

endmodule

`default_nettype wire

// ==== hw/gpio_ctrl.sv ====
/*
 * GPIO control
 * Output register, per pin function selects and the output pin mux
 */
`default_nettype none

`include "periph_settings.svh"

module gpio_ctrl (
    input  wire logic                   clk,
    input  wire logic                   rst_n,
    input  wire logic                   i_write,
    input  wire logic [5:0]             i_ofs,
    input  wire periph_pkg::byte_t      i_wdata,
    input  wire periph_pkg::pins_t      i_ui_in,
    input  wire periph_pkg::slot_pins_t i_slot_pins,
    output periph_pkg::word_t           o_rdata,
    output periph_pkg::pins_t           o_uo_out
);
    import periph_pkg::*;

    localparam int PIN_IDX_W = $clog2(`PERIPH_PINS);
    // A 4-bit slot index reaches 16 slots
    localparam int SEL_RANGE = 16;

    pins_t                gpio_out;
    func_sel_t            func_sel [`PERIPH_PINS];
    logic [5:0]           sel_rel;
    logic                 sel_hit;
    logic [PIN_IDX_W-1:0] sel_idx;
    pins_t                slot_pins_ext [SEL_RANGE];

    // Function selects are word spaced from the select base
    assign sel_rel = i_ofs - `PERIPH_GPIO_SEL_OFS;
    assign sel_hit = i_ofs >= `PERIPH_GPIO_SEL_OFS && sel_rel[1:0] == 2'b00 &&
                     sel_rel[5:2] < 4'(`PERIPH_PINS);
    assign sel_idx = sel_rel[2 +: PIN_IDX_W];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out <= '0;
            for (int k = 0; k < `PERIPH_PINS; k++) begin
                func_sel[k] <= FUNC_SEL_RESET;
            end
        end else if (i_write) begin
            if (i_ofs == `PERIPH_GPIO_OUT_OFS) begin
                gpio_out <= i_wdata;
            end
            if (sel_hit) begin
                func_sel[sel_idx] <= i_wdata[4:0];
            end
        end
    end

    // Read data is zero extended
    always_comb begin
        o_rdata = '0;
        if (i_ofs == `PERIPH_GPIO_OUT_OFS) begin
            o_rdata[`PERIPH_PINS-1:0] = gpio_out;
        end else if (i_ofs == `PERIPH_GPIO_IN_OFS) begin
            o_rdata[`PERIPH_PINS-1:0] = i_ui_in;
        end else if (sel_hit) begin
            o_rdata[4:0] = func_sel[sel_idx];
        end
    end

    // Missing slots read as low pins
    for (genvar s = 0; s < SEL_RANGE; s++) begin : g_slot_pad
        if (s < `PERIPH_NUM_SLOTS) begin : g_used
            assign slot_pins_ext[s] = i_slot_pins[s];
        end else begin : g_empty
            assign slot_pins_ext[s] = '0;
        end
    end

    // Per pin source mux, unknown codes drive low
    for (genvar k = 0; k < `PERIPH_PINS; k++) begin : g_pin
        assign o_uo_out[k] = func_sel[k][4]                ? slot_pins_ext[func_sel[k][3:0]][k] :
                             func_sel[k][3:0] == FUNC_GPIO ? gpio_out[k] :
                                                             1'b0;
    end

endmodule

`default_nettype wire

// ==== hw/read_return.sv ====
/*
 * Read return path
 * Picks read data by address, registers it and holds it until read complete
 */
`default_nettype none

`include "periph_settings.svh"

module read_return #(
    parameter int NUM_SLOTS = `PERIPH_NUM_SLOTS
) (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic [`PERIPH_ADDR_W-1:0] i_addr,
    input  wire periph_pkg::size_code_t    i_data_read_n,
    input  wire periph_pkg::size_code_t    i_data_write_n,
    input  wire logic                      i_data_read_complete,
    input  wire periph_pkg::word_t         i_gpio_rdata,
    slot_bus_if.reader                     slot_bus [NUM_SLOTS],
    output periph_pkg::word_t              o_data,
    output logic                           o_data_ready
);
    import periph_pkg::*;

    // A 4-bit slot index reaches 16 slots
    localparam int MAX_SLOTS = 16;

    byte_t slot_rdata [MAX_SLOTS];
    word_t pick_data;
    word_t data_r;
    logic  data_hold;
    logic  ready_r;
    logic  read_req;
    logic  write_req;

    assign read_req  = i_data_read_n != SIZE_IDLE;
    assign write_req = i_data_write_n != SIZE_IDLE;

    // Unused slot indices read 0
    for (genvar s = 0; s < MAX_SLOTS; s++) begin : g_slot_pad
        if (s < NUM_SLOTS) begin : g_used
            assign slot_rdata[s] = slot_bus[s].rdata;
        end else begin : g_empty
            assign slot_rdata[s] = '0;
        end
    end

    // Every source answers in the same cycle
    always_comb begin
        if (i_addr[`PERIPH_SLOT_BIT]) begin
            pick_data = {24'h0, slot_rdata[i_addr[7:4]]};
        end else if (i_addr[9:6] == 4'(`PERIPH_GPIO_BLOCK)) begin
            pick_data = i_gpio_rdata;
        end else begin
            pick_data = '0;
        end
    end

    // First read cycle captures, later ones keep the held value
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            data_hold <= 1'b0;
            ready_r   <= 1'b0;
        end else begin
            if (i_data_read_complete) begin
                data_hold <= 1'b0;
            end
            if (!data_hold && read_req) begin
                data_hold <= 1'b1;
            end
            ready_r <= read_req;
        end
    end

    always_ff @(posedge clk) begin
        if (!data_hold && read_req) begin
            data_r <= pick_data;
        end
    end

    assign o_data       = data_r;
    // Writes are acknowledged in their own cycle
    assign o_data_ready = ready_r || write_req;

endmodule

`default_nettype wire

// ==== hw/periph_top.sv ====
/*
 * Peripheral bus block top level
 * Decoder, GPIO, a row of byte slots and the read-return path
 */
`default_nettype none

`include "periph_settings.svh"

module periph_top (
    input  wire        clk,
    input  wire        rst_n,
    input  wire [7:0]  i_ui_in,
    output wire [7:0]  o_uo_out,
    input  wire [10:0] i_addr,
    input  wire [31:0] i_data,
    input  wire [1:0]  i_data_write_n,
    input  wire [1:0]  i_data_read_n,
    input  wire        i_data_read_complete,
    output wire [31:0] o_data,
    output wire        o_data_ready
);
    import periph_pkg::*;

    localparam int NUM_SLOTS = `PERIPH_NUM_SLOTS;

    logic       gpio_write;
    logic [5:0] gpio_ofs;
    byte_t      gpio_wdata;
    word_t      gpio_rdata;
    slot_pins_t slot_pins;

    slot_bus_if slot_bus [NUM_SLOTS] ();

    bus_decoder #(
        .NUM_SLOTS(NUM_SLOTS)
    ) u_decoder (
        .i_addr         (i_addr),
        .i_data         (i_data),
        .i_data_write_n (i_data_write_n),
        .o_gpio_write   (gpio_write),
        .o_gpio_ofs     (gpio_ofs),
        .o_wdata        (gpio_wdata),
        .slot_bus       (slot_bus)
    );

    for (genvar s = 0; s < NUM_SLOTS; s++) begin : g_slot
        byte_periph u_slot (
            .clk     (clk),
            .rst_n   (rst_n),
            .i_ui_in (i_ui_in),
            .bus     (slot_bus[s])
        );

        assign slot_pins[s] = slot_bus[s].pins;
    end

    gpio_ctrl u_gpio (
        .clk         (clk),
        .rst_n       (rst_n),
        .i_write     (gpio_write),
        .i_ofs       (gpio_ofs),
        .i_wdata     (gpio_wdata),
        .i_ui_in     (i_ui_in),
        .i_slot_pins (slot_pins),
        .o_rdata     (gpio_rdata),
        .o_uo_out    (o_uo_out)
    );

    read_return #(
        .NUM_SLOTS(NUM_SLOTS)
    ) u_read (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_addr               (i_addr),
        .i_data_read_n        (i_data_read_n),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_complete (i_data_read_complete),
        .i_gpio_rdata         (gpio_rdata),
        .slot_bus             (slot_bus),
        .o_data               (o_data),
        .o_data_ready         (o_data_ready)
    );

endmodule

`default_nettype wire

// ==== verif/periph_tb.sv ====
/*
 * Peripheral bus block testbench
 * Exercises GPIO, byte slots, pin routing and the read hold over the CPU bus
 */
`default_nettype none

`include "periph_settings.svh"

module periph_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int         NUM_SLOTS      = `PERIPH_NUM_SLOTS;
    localparam int         PINS           = `PERIPH_PINS;
    localparam int         TIMEOUT_CYCLES = 3000;
    localparam logic [1:0] IDLE           = 2'b11;
    localparam logic [1:0] WORD           = 2'b10;

    logic        clk;
    logic        rst_n;
    logic [7:0]  i_ui_in;
    logic [7:0]  o_uo_out;
    logic [10:0] i_addr;
    logic [31:0] i_data;
    logic [1:0]  i_data_write_n;
    logic [1:0]  i_data_read_n;
    logic        i_data_read_complete;
    logic [31:0] o_data;
    logic        o_data_ready;

    // Expected register state
    logic [7:0]  slot_model [NUM_SLOTS][4];
    logic [7:0]  gpio_model;
    logic [4:0]  sel_model [PINS];
    logic [15:0] lfsr_state;
    int          cycle_count = 0;

    periph_top dut0 (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_ui_in              (i_ui_in),
        .o_uo_out             (o_uo_out),
        .i_addr               (i_addr),
        .i_data               (i_data),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_n        (i_data_read_n),
        .i_data_read_complete (i_data_read_complete),
        .o_data               (o_data),
        .o_data_ready         (o_data_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp)
        else stop_with_error($sformatf("mismatch %s: got 0x%08h, expected 0x%08h",
                                       name, got, exp));
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_error("timeout: the tests did not finish within the cycle limit");
        end
    end

    // Writes are acknowledged in their own cycle
    a_write_ack: assert property (@(posedge clk) disable iff (!rst_n)
        (i_data_write_n != IDLE) |-> o_data_ready)
    else stop_with_error("mismatch o_data_ready on write: got 0x0, expected 0x1");

    // Read data comes exactly one cycle after the request
    a_read_early: assert property (@(posedge clk) disable iff (!rst_n)
        ($rose(i_data_read_n != IDLE) && (i_data_write_n == IDLE)) |-> !o_data_ready)
    else stop_with_error("mismatch o_data_ready in request cycle: got 0x1, expected 0x0");

    a_read_late: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(i_data_read_n != IDLE) |=> o_data_ready)
    else stop_with_error("mismatch o_data_ready after request: got 0x0, expected 0x1");

    // Fibonacci LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic random_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            b = {b[6:0], lfsr_state[0]};
        end
    endtask

    function automatic logic [10:0] slot_addr(input int s, input int ofs);
        return 11'(32'h400 + 16 * s + ofs);
    endfunction

    function automatic logic [10:0] sel_addr(input int k);
        return 11'(32'h060 + 4 * k);
    endfunction

    // Expected pins from the slot select and GPIO code rules
    function automatic logic [7:0] expected_pins();
        logic [7:0] pins;
        int         idx;
        for (int k = 0; k < PINS; k++) begin
            idx = int'(sel_model[k][3:0]);
            if (sel_model[k][4]) begin
                pins[k] = (idx < NUM_SLOTS) ? slot_model[idx][0][k] : 1'b0;
            end else begin
                pins[k] = (idx == 1) ? gpio_model[k] : 1'b0;
            end
        end
        return pins;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #0.5;
    endtask

    task automatic write_word(input logic [10:0] addr, input logic [31:0] data);
        i_addr         = addr;
        i_data         = data;
        i_data_write_n = WORD;
        next_cycle();
        i_data_write_n = IDLE;
    endtask

    task automatic write_slot(input int s, input int ofs, input logic [7:0] b);
        write_word(slot_addr(s, ofs), 32'(b));
        if (s < NUM_SLOTS && ofs < 4) begin
            slot_model[s][ofs] = b;
        end
    endtask

    task automatic write_sel(input int k, input logic [7:0] v);
        write_word(sel_addr(k), 32'(v));
        sel_model[k] = v[4:0];
        check_value("o_uo_out", 32'(o_uo_out), 32'(expected_pins()));
    endtask

    // Raises the request and drops it once data is ready
    task automatic wait_read_data(input logic [10:0] addr, output logic [31:0] data);
        i_addr        = addr;
        i_data_read_n = WORD;
        next_cycle();
        while (o_data_ready !== 1'b1) begin
            next_cycle();
        end
        data          = o_data;
        i_data_read_n = IDLE;
    endtask

    task automatic read_word(input logic [10:0] addr, output logic [31:0] data);
        wait_read_data(addr, data);
        i_data_read_complete = 1'b1;
        next_cycle();
        i_data_read_complete = 1'b0;
    endtask

    task automatic read_check(input logic [10:0] addr, input logic [31:0] exp);
        logic [31:0] got;
        read_word(addr, got);
        check_value($sformatf("o_data @0x%03h", addr), got, exp);
    endtask

    initial begin
        logic [7:0]  b;
        logic [7:0]  nb;
        logic [31:0] exp;
        logic [31:0] got;
        lfsr_state           = 16'd71;
        rst_n                = 1'b0;
        i_ui_in              = 8'h00;
        i_addr               = 11'h000;
        i_data               = 32'h0;
        i_data_write_n       = IDLE;
        i_data_read_n        = IDLE;
        i_data_read_complete = 1'b0;
        gpio_model           = 8'h00;
        for (int k = 0; k < PINS; k++) begin
            sel_model[k] = 5'h01;
        end
        for (int s = 0; s < NUM_SLOTS; s++) begin
            for (int r = 0; r < 4; r++) begin
                slot_model[s][r] = 8'h00;
            end
        end
        repeat (4) @(posedge clk);
        #0.5;
        rst_n = 1'b1;

        // Reset state
        check_value("o_uo_out", 32'(o_uo_out), 32'h0);
        check_value("o_data_ready", 32'(o_data_ready), 32'h0);
        for (int k = 0; k < PINS; k++) begin
            read_check(sel_addr(k), 32'h1);
        end

        // GPIO output and input registers
        random_byte(b);
        write_word(11'h040, 32'(b));
        gpio_model = b;
        check_value("o_uo_out", 32'(o_uo_out), 32'(expected_pins()));
        read_check(11'h040, 32'(b));
        random_byte(b);
        i_ui_in = b;
        read_check(11'h044, 32'(b));
        read_check(11'h048, 32'h0);

        // Byte slots including indices past the last slot
        for (int s = 0; s < 16; s++) begin
            for (int ofs = 0; ofs < 4; ofs++) begin
                random_byte(b);
                write_slot(s, ofs, b);
            end
        end
        for (int s = 0; s < 16; s++) begin
            for (int ofs = 0; ofs < 16; ofs++) begin
                exp = 32'h0;
                if (s < NUM_SLOTS && ofs < 4) begin
                    exp = 32'(slot_model[s][ofs]);
                end else if (s < NUM_SLOTS && ofs == 4) begin
                    exp = 32'(i_ui_in);
                end
                read_check(slot_addr(s, ofs), exp);
            end
        end
        read_check(11'h000, 32'h0);
        read_check(11'h0c0, 32'h0);

        // Pin routing to slots
        for (int k = 0; k < PINS; k++) begin
            write_sel(k, 8'(8'h10 | (k % NUM_SLOTS)));
        end
        for (int s = 0; s < NUM_SLOTS; s++) begin
            random_byte(b);
            write_slot(s, 0, b);
            check_value("o_uo_out", 32'(o_uo_out), 32'(expected_pins()));
        end
        read_check(sel_addr(PINS - 1), 32'(sel_model[PINS - 1]));

        // Codes without a source drive low
        write_word(11'h040, 32'hff);
        gpio_model = 8'hff;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            write_slot(s, 0, 8'hff);
        end
        check_value("o_uo_out", 32'(o_uo_out), 32'hff);
        write_sel(0, 8'h00);
        write_sel(1, 8'h02);
        write_sel(2, 8'h0f);
        if (NUM_SLOTS < 16) begin
            write_sel(3, 8'(32'h10 + NUM_SLOTS));
        end
        write_sel(4, 8'h01);

        // Captured data is held until read complete
        random_byte(b);
        nb = ~b;
        write_slot(NUM_SLOTS - 1, 2, b);
        wait_read_data(slot_addr(NUM_SLOTS - 1, 2), got);
        check_value("o_data", got, 32'(b));
        write_slot(NUM_SLOTS - 1, 2, nb);
        wait_read_data(slot_addr(NUM_SLOTS - 1, 2), got);
        check_value("o_data held", got, 32'(b));
        i_data_read_complete = 1'b1;
        next_cycle();
        i_data_read_complete = 1'b0;
        read_check(slot_addr(NUM_SLOTS - 1, 2), 32'(nb));

        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+hw
hw/periph_pkg.sv
hw/slot_bus_if.sv
hw/bus_decoder.sv
hw/byte_periph.sv
hw/gpio_ctrl.sv
hw/read_return.sv
hw/periph_top.sv
verif/periph_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --assert --timescale 1ns/1ps -j 0 \
		--top-module periph_tb -f compile.f -o Vperiph_tb
	./obj_dir/Vperiph_tb

clean:
	rm -rf obj_dir
